// ==== dcache_consts.svh ====
/* Size constants for the direct-mapped write-through data cache.
   Included by the package and by every module that sizes a port or array. */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Bus widths
`define DC_ADDR_W 32
`define DC_DATA_W 32
`define DC_SEL_W 4

// Line geometry, 64 lines of 4 words
`define DC_LINE_WORDS 4
`define DC_NUM_LINES 64

// Address split, tag | index | byte offset in line
`define DC_OFF_W 4
`define DC_IDX_W 6
`define DC_TAG_W 22

// Sanity relation, tag + index + offset must equal address width
// 22 + 6 + 4 = 32

`endif

// ==== dcache_pkg.sv ====
/* Types passed between the request, lookup and memory stages of the cache.
   Imported by the modules that build or read these structs. */
`include "dcache_consts.svh"
`default_nettype none

package dcache_pkg;

  // Word position inside one cache line
  typedef logic [$clog2(`DC_LINE_WORDS)-1:0] dc_word_idx_t;

  typedef enum logic {
    DC_MEM_REFILL,
    DC_MEM_WRITE
  } dc_mem_kind_e;

  // One captured requester operation
  typedef struct packed {
    logic                  we;
    logic [`DC_ADDR_W-1:0] adr;
    logic [`DC_DATA_W-1:0] dat_w;
    logic [`DC_SEL_W-1:0]  sel;
  } dc_req_t;

  // Result of a tag compare and word read
  typedef struct packed {
    logic                  hit;
    logic [`DC_DATA_W-1:0] rd_word;
    logic                  miss;
  } dc_lookup_t;

  // Work item for the memory engine
  typedef struct packed {
    dc_mem_kind_e          kind;
    logic [`DC_ADDR_W-1:0] adr;
    logic [`DC_DATA_W-1:0] dat_w;
    logic [`DC_SEL_W-1:0]  sel;
  } dc_mem_cmd_t;

  // One word returned during a line refill
  typedef struct packed {
    dc_word_idx_t          word;
    logic [`DC_DATA_W-1:0] data;
    logic                  last;
  } dc_fill_t;

endpackage

`default_nettype wire

// ==== dcache_req_stage.sv ====
/* Requester-side Wishbone classic slave. Captures one cycle into a request
   struct, waits for the lookup stage to finish, then returns a one-cycle ack. */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module dcache_req_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`DC_ADDR_W-1:0] adr,
  input  logic [`DC_DATA_W-1:0] dat_w,
  input  logic [`DC_SEL_W-1:0]  sel,
  output logic                  ack,
  output logic [`DC_DATA_W-1:0] dat_r,
  output dcache_pkg::dc_req_t   req,
  output logic                  req_valid,
  input  logic                  done,
  input  logic [`DC_DATA_W-1:0] rd_data
);

  logic busy;
  logic start;
  logic finish;

  // Held stb is ignored while busy and during the ack beat itself
  assign start  = cyc && stb && !busy && !ack;
  assign finish = busy && done;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
      ack       <= 1'b0;
    end else begin
      req_valid <= start;
      ack       <= finish;
      if (start) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy <= 1'b0;
      end
    end
  end

  // Request payload stays stable until the next accepted cycle
  always_ff @(posedge clk) begin
    if (start) begin
      req.we    <= we;
      req.adr   <= adr;
      req.dat_w <= dat_w;
      req.sel   <= sel;
    end
    if (finish) begin
      dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_lookup.sv ====
/* Tag, valid and data storage of the cache with hit detection.
   Serves read hits, starts refills on read misses and write-through on writes. */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module dcache_lookup (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_pkg::dc_req_t     req,
  input  logic                    req_valid,
  output dcache_pkg::dc_mem_cmd_t cmd,
  output logic                    cmd_valid,
  input  dcache_pkg::dc_fill_t    fill,
  input  logic                    fill_valid,
  input  logic                    mem_done,
  output logic                    done,
  output logic [`DC_DATA_W-1:0]   rd_data
);

  import dcache_pkg::*;

  typedef enum logic [2:0] {
    LK_IDLE,
    LK_LOOK,
    LK_REFILL,
    LK_REREAD,
    LK_WRITE
  } lk_state_e;

  lk_state_e                state;
  logic [`DC_DATA_W-1:0]    data_mem [`DC_NUM_LINES*`DC_LINE_WORDS];
  logic [`DC_TAG_W-1:0]     tag_mem  [`DC_NUM_LINES];
  logic [`DC_NUM_LINES-1:0] valid;
  logic [`DC_IDX_W-1:0]     idx;
  logic [`DC_TAG_W-1:0]     tag;
  dc_word_idx_t             word;
  dc_lookup_t               look;
  logic [`DC_DATA_W-1:0]    merged;

  assign idx  = req.adr[`DC_OFF_W +: `DC_IDX_W];
  assign tag  = req.adr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign word = req.adr[`DC_OFF_W-1 -: $bits(dc_word_idx_t)];

  // Writes never allocate, so only a read miss asks for a refill
  always_comb begin
    look.hit     = valid[idx] && (tag_mem[idx] == tag);
    look.miss    = !look.hit && !req.we;
    look.rd_word = data_mem[{idx, word}];
  end

  // Byte merge of write data into the stored word
  always_comb begin
    merged = look.rd_word;
    for (int b = 0; b < `DC_SEL_W; b++) begin
      if (req.sel[b]) begin
        merged[8*b +: 8] = req.dat_w[8*b +: 8];
      end
    end
  end

  assign done = (state == LK_LOOK && !req.we && look.hit) ||
                (state == LK_REREAD) ||
                (state == LK_WRITE && mem_done);
  assign rd_data = look.rd_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= LK_IDLE;
      cmd_valid <= 1'b0;
      valid     <= '0;
    end else begin
      cmd_valid <= 1'b0;
      case (state)
        LK_IDLE: begin
          if (req_valid) begin
            state <= LK_LOOK;
          end
        end
        LK_LOOK: begin
          if (req.we) begin
            cmd_valid <= 1'b1;
            state     <= LK_WRITE;
          end else if (look.miss) begin
            cmd_valid <= 1'b1;
            state     <= LK_REFILL;
          end else begin
            state <= LK_IDLE;
          end
        end
        LK_REFILL: begin
          if (fill_valid && fill.last) begin
            valid[idx] <= 1'b1;
          end
          if (mem_done) begin
            state <= LK_REREAD;
          end
        end
        LK_REREAD: state <= LK_IDLE;
        LK_WRITE: begin
          if (mem_done) begin
            state <= LK_IDLE;
          end
        end
        default: state <= LK_IDLE;
      endcase
    end
  end

  // Line fill from memory, or merge on a write hit
  always_ff @(posedge clk) begin
    if (state == LK_REFILL && fill_valid) begin
      data_mem[{idx, fill.word}] <= fill.data;
      if (fill.last) begin
        tag_mem[idx] <= tag;
      end
    end else if (state == LK_LOOK && req.we && look.hit) begin
      data_mem[{idx, word}] <= merged;
    end
  end

  // Refill starts at the line base, write-through keeps the full address
  always_ff @(posedge clk) begin
    if (state == LK_LOOK) begin
      cmd.kind  <= req.we ? DC_MEM_WRITE : DC_MEM_REFILL;
      cmd.adr   <= req.we ? req.adr :
                   {req.adr[`DC_ADDR_W-1:`DC_OFF_W], {`DC_OFF_W{1'b0}}};
      cmd.dat_w <= req.dat_w;
      cmd.sel   <= req.sel;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_mem_ctrl.sv ====
/* Memory-side Wishbone classic master. Runs 4-word line refills inside one
   bus cycle and single write-through transfers, one command at a time. */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module dcache_mem_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_pkg::dc_mem_cmd_t cmd,
  input  logic                    cmd_valid,
  output dcache_pkg::dc_fill_t    fill,
  output logic                    fill_valid,
  output logic                    mem_done,
  output logic                    mem_cyc,
  output logic                    mem_stb,
  output logic                    mem_we,
  output logic [`DC_ADDR_W-1:0]   mem_adr,
  output logic [`DC_DATA_W-1:0]   mem_dat_w,
  output logic [`DC_SEL_W-1:0]    mem_sel,
  input  logic [`DC_DATA_W-1:0]   mem_dat_r,
  input  logic                    mem_ack
);

  import dcache_pkg::*;

  typedef enum logic [1:0] {
    MC_IDLE,
    MC_REFILL,
    MC_WRITE
  } mc_state_e;

  mc_state_e    state;
  dc_word_idx_t cnt;
  logic         xfer_done;
  logic         last_word;
  logic         start;

  assign xfer_done = mem_stb && mem_ack;
  assign last_word = (cnt == dc_word_idx_t'(`DC_LINE_WORDS - 1));
  assign start     = (state == MC_IDLE) && cmd_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= MC_IDLE;
      cnt        <= '0;
      mem_cyc    <= 1'b0;
      mem_stb    <= 1'b0;
      mem_we     <= 1'b0;
      fill_valid <= 1'b0;
      mem_done   <= 1'b0;
    end else begin
      fill_valid <= 1'b0;
      mem_done   <= 1'b0;
      case (state)
        MC_IDLE: begin
          if (cmd_valid) begin
            mem_cyc <= 1'b1;
            mem_stb <= 1'b1;
            cnt     <= '0;
            if (cmd.kind == DC_MEM_WRITE) begin
              mem_we <= 1'b1;
              state  <= MC_WRITE;
            end else begin
              mem_we <= 1'b0;
              state  <= MC_REFILL;
            end
          end
        end
        MC_REFILL: begin
          // Stb stays up between words, address steps on each ack
          if (xfer_done) begin
            fill_valid <= 1'b1;
            if (last_word) begin
              mem_cyc  <= 1'b0;
              mem_stb  <= 1'b0;
              mem_done <= 1'b1;
              state    <= MC_IDLE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        MC_WRITE: begin
          if (xfer_done) begin
            mem_cyc  <= 1'b0;
            mem_stb  <= 1'b0;
            mem_we   <= 1'b0;
            mem_done <= 1'b1;
            state    <= MC_IDLE;
          end
        end
        default: state <= MC_IDLE;
      endcase
    end
  end

  // Bus payload and fill word
  always_ff @(posedge clk) begin
    if (start) begin
      mem_adr   <= cmd.adr;
      mem_dat_w <= cmd.dat_w;
      mem_sel   <= (cmd.kind == DC_MEM_WRITE) ? cmd.sel : '1;
    end else if (state == MC_REFILL && xfer_done) begin
      mem_adr <= mem_adr + `DC_ADDR_W'(`DC_SEL_W);
    end
    if (state == MC_REFILL && xfer_done) begin
      fill.word <= cnt;
      fill.data <= mem_dat_r;
      fill.last <= last_word;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
/* Top level of the data cache. Joins the request stage, lookup stage and
   memory engine; exposes the requester and memory Wishbone ports. */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module dcache_top (
  input  logic                  clk,
  input  logic                  rst,
  // Requester side
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`DC_ADDR_W-1:0] adr,
  input  logic [`DC_DATA_W-1:0] dat_w,
  input  logic [`DC_SEL_W-1:0]  sel,
  output logic [`DC_DATA_W-1:0] dat_r,
  output logic                  ack,
  // Memory side
  output logic                  mem_cyc,
  output logic                  mem_stb,
  output logic                  mem_we,
  output logic [`DC_ADDR_W-1:0] mem_adr,
  output logic [`DC_DATA_W-1:0] mem_dat_w,
  output logic [`DC_SEL_W-1:0]  mem_sel,
  input  logic [`DC_DATA_W-1:0] mem_dat_r,
  input  logic                  mem_ack
);

  import dcache_pkg::*;

  dc_req_t               req;
  logic                  req_valid;
  logic                  done;
  logic [`DC_DATA_W-1:0] rd_data;
  dc_mem_cmd_t           cmd;
  logic                  cmd_valid;
  dc_fill_t              fill;
  logic                  fill_valid;
  logic                  mem_done;

  dcache_req_stage u_req (
    .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .sel,
    .ack, .dat_r, .req, .req_valid, .done, .rd_data
  );

  dcache_lookup u_lookup (
    .clk, .rst, .req, .req_valid, .cmd, .cmd_valid,
    .fill, .fill_valid, .mem_done, .done, .rd_data
  );

  dcache_mem_ctrl u_mem (
    .clk, .rst, .cmd, .cmd_valid, .fill, .fill_valid, .mem_done,
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_sel,
    .mem_dat_r, .mem_ack
  );

endmodule

`default_nettype wire

// ==== tb_dcache_sva.sv ====
/* Protocol and reset assertions on the data cache ports.
   Bound into the cache top level; reports only through failing assertions. */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module tb_dcache_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  ack,
  input logic                  mem_cyc,
  input logic                  mem_stb,
  input logic                  mem_ack,
  input logic [`DC_ADDR_W-1:0] mem_adr
);

  // Requester ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  // Strobe only inside a bus cycle
  stb_inside_cyc: assert property (@(posedge clk) disable iff (rst) mem_stb |-> mem_cyc)
    else $error("mem_stb high while mem_cyc low");

  // Master holds the transfer until acknowledged
  stb_held: assert property (@(posedge clk) disable iff (rst) mem_stb && !mem_ack |=> mem_stb)
    else $error("mem_stb dropped before mem_ack");

  adr_held: assert property (@(posedge clk) disable iff (rst)
    mem_stb && !mem_ack |=> $stable(mem_adr))
    else $error("mem_adr changed while a transfer was waiting");

  reset_state: assert property (@(posedge clk) rst |=> !ack && !mem_cyc && !mem_stb)
    else $error("ack, mem_cyc or mem_stb high after a reset cycle");

endmodule

bind dcache_top tb_dcache_sva u_sva (
  .clk     (clk),
  .rst     (rst),
  .ack     (ack),
  .mem_cyc (mem_cyc),
  .mem_stb (mem_stb),
  .mem_ack (mem_ack),
  .mem_adr (mem_adr)
);

`default_nettype wire

// ==== tb_dcache.sv ====
/* Testbench for the data cache. Applies a table of requester operations against a
   wait-state memory model and checks data, transfer counts and hit latency. */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module tb_dcache;

  localparam int TIMEOUT_CYCLES = 200;

  typedef struct packed {
    logic                  we;
    logic [`DC_ADDR_W-1:0] adr;
    logic [`DC_DATA_W-1:0] data;
    logic [`DC_SEL_W-1:0]  sel;
    logic [3:0]            exp_rd;
    logic                  exp_hit;
  } stim_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`DC_ADDR_W-1:0] adr;
  logic [`DC_DATA_W-1:0] dat_w;
  logic [`DC_SEL_W-1:0]  sel;
  logic [`DC_DATA_W-1:0] dat_r;
  logic                  ack;
  logic                  mem_cyc;
  logic                  mem_stb;
  logic                  mem_we;
  logic [`DC_ADDR_W-1:0] mem_adr;
  logic [`DC_DATA_W-1:0] mem_dat_w;
  logic [`DC_SEL_W-1:0]  mem_sel;
  logic [`DC_DATA_W-1:0] mem_dat_r = '0;
  logic                  mem_ack = 1'b0;

  // Memory contents and the expected image, keyed by word address
  logic [`DC_DATA_W-1:0] mem_words    [logic [`DC_ADDR_W-3:0]];
  logic [`DC_DATA_W-1:0] shadow_words [logic [`DC_ADDR_W-3:0]];
  logic [`DC_ADDR_W-1:0] rd_addrs [$];
  logic [`DC_ADDR_W-1:0] wr_adr = '0;
  logic [`DC_SEL_W-1:0]  wr_sel = '0;
  int                    rd_count = 0;
  int                    wr_count = 0;
  int                    wait_left = 0;
  int                    seed = 32'hb960_79e0;

  stim_t stim_q [$];
  string names [$];
  int    mismatches = 0;
  int    failures = 0;
  bit    hung = 1'b0;

  always #2 clk = ~clk;

  dcache_top u_dcache_top (
    .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack,
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_sel,
    .mem_dat_r, .mem_ack
  );

  // Untouched memory reads back a pattern of its full address
  function automatic logic [`DC_DATA_W-1:0] fill_word(input logic [`DC_ADDR_W-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [`DC_DATA_W-1:0] merge_bytes(
    input logic [`DC_DATA_W-1:0] old_word,
    input logic [`DC_DATA_W-1:0] new_word,
    input logic [`DC_SEL_W-1:0]  byte_sel
  );
    logic [`DC_DATA_W-1:0] r;
    r = old_word;
    for (int b = 0; b < `DC_SEL_W; b++) begin
      if (byte_sel[b]) begin
        r[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [`DC_DATA_W-1:0] mem_read(input logic [`DC_ADDR_W-1:0] a);
    if (mem_words.exists(a[`DC_ADDR_W-1:2])) begin
      return mem_words[a[`DC_ADDR_W-1:2]];
    end
    return fill_word({a[`DC_ADDR_W-1:2], 2'b00});
  endfunction

  function automatic logic [`DC_DATA_W-1:0] shadow_read(input logic [`DC_ADDR_W-1:0] a);
    if (shadow_words.exists(a[`DC_ADDR_W-1:2])) begin
      return shadow_words[a[`DC_ADDR_W-1:2]];
    end
    return fill_word({a[`DC_ADDR_W-1:2], 2'b00});
  endfunction

  // Wishbone slave with 0 to 3 wait states per transfer
  always @(negedge clk) begin
    if (rst) begin
      mem_ack   <= 1'b0;
      wait_left = $unsigned($random(seed)) % 4;
    end else if (mem_ack) begin
      mem_ack   <= 1'b0;
      wait_left = $unsigned($random(seed)) % 4;
    end else if (mem_cyc && mem_stb) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        if (mem_we) begin
          mem_words[mem_adr[`DC_ADDR_W-1:2]] = merge_bytes(mem_read(mem_adr), mem_dat_w, mem_sel);
          wr_count++;
          wr_adr = mem_adr;
          wr_sel = mem_sel;
        end else begin
          mem_dat_r <= mem_read(mem_adr);
          rd_count++;
          rd_addrs.push_back(mem_adr);
        end
        mem_ack <= 1'b1;
      end
    end
  end

  task automatic check_word(input string name, input logic [`DC_DATA_W-1:0] exp,
                            input logic [`DC_DATA_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_adr(input string name, input logic [`DC_ADDR_W-1:0] exp,
                           input logic [`DC_ADDR_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      mismatches++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_sel(input string name, input logic [`DC_SEL_W-1:0] exp,
                           input logic [`DC_SEL_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic expect_idle(input string phase);
    if (ack !== 1'b0 || mem_cyc !== 1'b0) begin
      failures++;
      $display("ack or mem_cyc is not low %s", phase);
    end
  endtask

  task automatic add_stim(input string name, input logic op_we, input logic [31:0] a,
                          input logic [31:0] d, input logic [3:0] s, input int rd_cnt,
                          input logic hit);
    stim_t e;
    e.we      = op_we;
    e.adr     = a;
    e.data    = d;
    e.sel     = s;
    e.exp_rd  = 4'(rd_cnt);
    e.exp_hit = hit;
    stim_q.push_back(e);
    names.push_back(name);
  endtask

  // Lines a (0x1040) and c (0x2040) share index 4, line b is index 0x20
  task automatic build_table();
    add_stim("rd_miss_a",     1'b0, 32'h0000_1040, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_hit_a",      1'b0, 32'h0000_1048, 32'h0,         4'h0, 0, 1'b1);
    add_stim("rd_hit_a_w3",   1'b0, 32'h0000_104c, 32'h0,         4'h0, 0, 1'b1);
    add_stim("wr_hit_a",      1'b1, 32'h0000_1044, 32'hdead_beef, 4'b0101, 0, 1'b1);
    add_stim("rd_merged_a",   1'b0, 32'h0000_1044, 32'h0,         4'h0, 0, 1'b1);
    add_stim("wr_miss_b",     1'b1, 32'h0000_3200, 32'h1234_5678, 4'b1100, 0, 1'b0);
    add_stim("rd_after_wr_b", 1'b0, 32'h0000_3200, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_hit_b",      1'b0, 32'h0000_3204, 32'h0,         4'h0, 0, 1'b1);
    add_stim("rd_evict_c",    1'b0, 32'h0000_2040, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_evict_a",    1'b0, 32'h0000_1044, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_evict_c2",   1'b0, 32'h0000_204c, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_evict_a2",   1'b0, 32'h0000_1040, 32'h0,         4'h0, 4, 1'b0);
    add_stim("wr_full_a",     1'b1, 32'h0000_1040, 32'h0bad_f00d, 4'b1111, 0, 1'b1);
    add_stim("rd_full_a",     1'b0, 32'h0000_1040, 32'h0,         4'h0, 0, 1'b1);
    add_stim("wr_byte_c",     1'b1, 32'h0000_2048, 32'h00c3_5a00, 4'b0010, 0, 1'b0);
    add_stim("rd_byte_c",     1'b0, 32'h0000_2048, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_back_a",     1'b0, 32'h0000_1040, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_miss_top",   1'b0, 32'hffff_fffc, 32'h0,         4'h0, 4, 1'b0);
    add_stim("rd_hit_top",    1'b0, 32'hffff_fff0, 32'h0,         4'h0, 0, 1'b1);
  endtask

  task automatic run_op(input int i);
    stim_t                 s;
    string                 name;
    int                    rd_base;
    int                    wr_base;
    int                    q_base;
    int                    cycles;
    logic [`DC_DATA_W-1:0] got;
    logic [`DC_ADDR_W-1:0] line_base;
    s         = stim_q[i];
    name      = names[i];
    rd_base   = rd_count;
    wr_base   = wr_count;
    q_base    = rd_addrs.size();
    line_base = {s.adr[`DC_ADDR_W-1:`DC_OFF_W], {`DC_OFF_W{1'b0}}};
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = s.we;
    adr   = s.adr;
    dat_w = s.data;
    sel   = s.sel;
    cycles = 0;
    while (ack !== 1'b1 && cycles <= TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    got = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (ack !== 1'b1) begin
      failures++;
      hung = 1'b1;
      $display("timeout: no ack within %0d cycles in test %s", TIMEOUT_CYCLES, name);
    end else if (s.we) begin
      shadow_words[s.adr[`DC_ADDR_W-1:2]] = merge_bytes(shadow_read(s.adr), s.data, s.sel);
      check_count({name, " mem reads"}, 0, rd_count - rd_base);
      check_count({name, " mem writes"}, 1, wr_count - wr_base);
      check_adr({name, " write adr"}, s.adr, wr_adr);
      check_sel({name, " write sel"}, s.sel, wr_sel);
      check_word({name, " memory word"}, shadow_read(s.adr), mem_read(s.adr));
    end else begin
      check_word({name, " read data"}, shadow_read(s.adr), got);
      check_count({name, " mem reads"}, int'(s.exp_rd), rd_count - rd_base);
      check_count({name, " mem writes"}, 0, wr_count - wr_base);
      if (rd_count - rd_base == `DC_LINE_WORDS) begin
        for (int k = 0; k < `DC_LINE_WORDS; k++) begin
          check_adr({name, " refill adr"}, line_base + `DC_ADDR_W'(4 * k),
                    rd_addrs[q_base + k]);
        end
      end
      // Ack edges counted from the edge that first sampled stb
      if (s.exp_hit) begin
        check_count({name, " hit latency"}, 2, cycles - 1);
      end
    end
  endtask

  initial begin
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    sel   = '0;
    build_table();
    repeat (10) begin
      @(negedge clk);
      expect_idle("during reset");
    end
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      expect_idle("after reset");
    end
    for (int i = 0; i < stim_q.size() && !hung; i++) begin
      run_op(i);
      @(negedge clk);
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
dcache_pkg.sv
dcache_req_stage.sv
dcache_lookup.sv
dcache_mem_ctrl.sv
dcache_top.sv
tb_dcache_sva.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=sim_dcache

verilator --binary --timing --assert -f files.f --top-module tb_dcache -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
